//--- common/gat_cfg.svh
`ifndef GAT_CFG_SVH
`define GAT_CFG_SVH

// ------------------------------
// feature memory geometry
// ------------------------------

// address width of the feature BRAM, 1024 words
`define FEAT_AW 10

// width of one node feature word
`define FEAT_DW 32

// first address written by layer 0
`define FEAT_BASE 16

// writes at or above this address raise the overflow flag
`define FEAT_ADDR_LIMIT 768

`endif

//--- common/gat_pkg.sv
`default_nettype none

`include "gat_cfg.svh"

package gat_pkg;

  // compute phases in execution order, also the bit order of the phase vectors
  typedef enum logic [1:0] {
    SPMM,
    DMVM,
    SM,
    AGGR
  } phase_e;

  typedef enum logic [2:0] {
    IDLE,
    RUN_SPMM,
    RUN_DMVM,
    RUN_SM,
    RUN_AGGR,
    WRITEBACK
  } ctrl_state_e;

  typedef logic [3:0]          phase_vec_t;  // one bit per phase_e entry
  typedef logic [`FEAT_AW-1:0] feat_addr_t;
  typedef logic [`FEAT_DW-1:0] feat_word_t;
  typedef logic [7:0]          node_cnt_t;

endpackage

`default_nettype wire

//--- hw/stage_engine.sv
`default_nettype none

module stage_engine (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start_i,
  input  gat_pkg::node_cnt_t  num_nodes_i,
  output logic                busy_o,
  output logic                done_o
);

  // remaining node cycles of the current phase
  gat_pkg::node_cnt_t remain_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      remain_q <= '0;
    end else if (start_i) begin
      remain_q <= num_nodes_i;  // one busy cycle per node
    end else if (remain_q != '0) begin
      remain_q <= remain_q - 8'd1;
    end
  end

  assign busy_o = (remain_q != '0);

  // done lands on the last busy cycle
  assign done_o = (remain_q == 8'd1);

endmodule

`default_nettype wire

//--- hw/gat_layer_ctrl.sv
`default_nettype none

module gat_layer_ctrl (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start_i,
  input  gat_pkg::phase_vec_t phase_done_i,
  input  logic                wb_done_i,
  output gat_pkg::phase_vec_t phase_start_o,
  output logic                wb_start_o,
  output logic                busy_o,
  output logic                done_o
);

  gat_pkg::ctrl_state_e state_q;
  gat_pkg::phase_vec_t  phase_start_q;
  logic                 wb_start_q;
  logic                 done_q;

  // ------------------------------
  // phase sequencing
  // ------------------------------

  // the strobes are registered, so each one follows the done of the phase before it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q       <= gat_pkg::IDLE;
      phase_start_q <= '0;
      wb_start_q    <= 1'b0;
      done_q        <= 1'b0;
    end else begin
      phase_start_q <= '0;
      wb_start_q    <= 1'b0;
      done_q        <= 1'b0;
      case (state_q)
        gat_pkg::IDLE: begin
          if (start_i) begin
            state_q                      <= gat_pkg::RUN_SPMM;
            phase_start_q[gat_pkg::SPMM] <= 1'b1;
          end
        end
        gat_pkg::RUN_SPMM: begin
          if (phase_done_i[gat_pkg::SPMM]) begin
            state_q                      <= gat_pkg::RUN_DMVM;
            phase_start_q[gat_pkg::DMVM] <= 1'b1;
          end
        end
        gat_pkg::RUN_DMVM: begin
          if (phase_done_i[gat_pkg::DMVM]) begin
            state_q                    <= gat_pkg::RUN_SM;
            phase_start_q[gat_pkg::SM] <= 1'b1;
          end
        end
        gat_pkg::RUN_SM: begin
          if (phase_done_i[gat_pkg::SM]) begin
            state_q                      <= gat_pkg::RUN_AGGR;
            phase_start_q[gat_pkg::AGGR] <= 1'b1;
          end
        end
        gat_pkg::RUN_AGGR: begin
          if (phase_done_i[gat_pkg::AGGR]) begin
            state_q    <= gat_pkg::WRITEBACK;
            wb_start_q <= 1'b1;
          end
        end
        gat_pkg::WRITEBACK: begin
          // wb_done_i comes with the last write, done_o one cycle later
          if (wb_done_i) begin
            state_q <= gat_pkg::IDLE;
            done_q  <= 1'b1;
          end
        end
        default: state_q <= gat_pkg::IDLE;
      endcase
    end
  end

  assign phase_start_o = phase_start_q;
  assign wb_start_o    = wb_start_q;
  assign done_o        = done_q;
  assign busy_o        = (state_q != gat_pkg::IDLE);  // start_i is ignored while high

endmodule

`default_nettype wire

//--- hw/feat_writeback.sv
`default_nettype none

`include "gat_cfg.svh"

module feat_writeback (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start_i,
  input  gat_pkg::node_cnt_t  num_nodes_i,
  output logic                wr_en_o,
  output gat_pkg::feat_addr_t wr_addr_o,
  output gat_pkg::feat_word_t wr_data_o,
  output logic                done_o
);

  logic               active_q;
  logic               last_node;
  logic [15:0]        layer_q;  // layers completed since reset
  gat_pkg::node_cnt_t node_q;
  gat_pkg::feat_addr_t layer_off;

  assign last_node = active_q && (node_q == num_nodes_i - 8'd1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active_q <= 1'b0;
      node_q   <= '0;
      layer_q  <= '0;
    end else if (start_i) begin
      active_q <= 1'b1;
      node_q   <= '0;
    end else if (last_node) begin
      active_q <= 1'b0;
      layer_q  <= layer_q + 16'd1;
    end else if (active_q) begin
      node_q <= node_q + 8'd1;
    end
  end

  // the product wraps like the address, only its low bits matter
  assign layer_off = gat_pkg::feat_addr_t'(layer_q * 16'(num_nodes_i));

  assign wr_en_o   = active_q;
  assign wr_addr_o = gat_pkg::feat_addr_t'(`FEAT_BASE + layer_off + gat_pkg::feat_addr_t'(node_q));
  assign wr_data_o = {layer_q, 8'd0, node_q};
  assign done_o    = last_node;  // with the last write

endmodule

`default_nettype wire

//--- hw/feat_bram.sv
`default_nettype none

`include "gat_cfg.svh"

module feat_bram (
  input  logic                clk,
  input  logic                wr_en_i,
  input  gat_pkg::feat_addr_t wr_addr_i,
  input  gat_pkg::feat_word_t wr_data_i,
  input  gat_pkg::feat_addr_t rd_addr_i,
  output gat_pkg::feat_word_t rd_data_o
);

  gat_pkg::feat_word_t mem [0:(1 << `FEAT_AW)-1];
  gat_pkg::feat_word_t rd_data_q;

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  // read data arrives one cycle after the address
  always_ff @(posedge clk) begin
    rd_data_q <= mem[rd_addr_i];
  end

  assign rd_data_o = rd_data_q;

endmodule

`default_nettype wire

//--- debug/debug_monitor.sv
`default_nettype none

`include "gat_cfg.svh"

module debug_monitor (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                clear_i,
  input  gat_pkg::phase_vec_t phase_start_i,
  input  logic                wr_en_i,
  input  gat_pkg::feat_addr_t wr_addr_i,
  input  gat_pkg::feat_word_t wr_data_i,
  input  gat_pkg::feat_addr_t watch_addr_i,
  output logic [31:0]         debug_flags_o,
  output logic [31:0]         debug_count_o,
  output logic [31:0]         debug_capture_o
);

  gat_pkg::phase_vec_t phase_seen_q;
  logic                wr_seen_q;
  logic                over_limit_q;
  logic                over_limit;
  logic                watch_hit;
  logic [31:0]         sm_count_q;
  gat_pkg::feat_word_t capture_q;

  assign over_limit = wr_en_i && (wr_addr_i >= `FEAT_ADDR_LIMIT);
  assign watch_hit  = wr_en_i && (wr_addr_i == watch_addr_i);

  // ------------------------------
  // sticky flags
  // ------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase_seen_q <= '0;
      wr_seen_q    <= 1'b0;
      over_limit_q <= 1'b0;
    end else if (clear_i) begin
      phase_seen_q <= '0;
      wr_seen_q    <= 1'b0;
      over_limit_q <= 1'b0;
    end else begin
      phase_seen_q <= phase_seen_q | phase_start_i;
      wr_seen_q    <= wr_seen_q | wr_en_i;
      over_limit_q <= over_limit_q | over_limit;
    end
  end

  // ------------------------------
  // softmax count and capture
  // ------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sm_count_q <= '0;
      capture_q  <= '0;
    end else if (clear_i) begin
      sm_count_q <= '0;
      capture_q  <= '0;
    end else begin
      if (phase_start_i[gat_pkg::SM]) begin
        sm_count_q <= sm_count_q + 32'd1;  // one per layer run
      end
      if (watch_hit) begin
        capture_q <= wr_data_i;  // keeps the latest layer's word
      end
    end
  end

  assign debug_flags_o   = {26'd0, over_limit_q, wr_seen_q, phase_seen_q};
  assign debug_count_o   = sm_count_q;
  assign debug_capture_o = capture_q;

endmodule

`default_nettype wire

//--- hw/gat_debug_top.sv
`default_nettype none

module gat_debug_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start_i,
  input  gat_pkg::node_cnt_t  num_nodes_i,
  input  gat_pkg::feat_addr_t watch_addr_i,
  input  logic                dbg_clear_i,
  input  gat_pkg::feat_addr_t rd_addr_i,
  output logic                busy_o,
  output logic                done_o,
  output gat_pkg::feat_word_t rd_data_o,
  output logic [31:0]         debug_flags_o,
  output logic [31:0]         debug_count_o,
  output logic [31:0]         debug_capture_o
);

  gat_pkg::phase_vec_t phase_start;
  gat_pkg::phase_vec_t phase_done;
  logic                wb_start;
  logic                wb_done;
  logic                wr_en;
  gat_pkg::feat_addr_t wr_addr;
  gat_pkg::feat_word_t wr_data;

  gat_layer_ctrl gat_layer_ctrl_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .start_i       (start_i),
    .phase_done_i  (phase_done),
    .wb_done_i     (wb_done),
    .phase_start_o (phase_start),
    .wb_start_o    (wb_start),
    .busy_o        (busy_o),
    .done_o        (done_o)
  );

  // one engine per phase, indexed in phase_e order
  for (genvar p = 0; p < 4; p++) begin : g_stage
    stage_engine stage_engine_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .start_i     (phase_start[p]),
      .num_nodes_i (num_nodes_i),
      .busy_o      (),
      .done_o      (phase_done[p])
    );
  end

  feat_writeback feat_writeback_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (wb_start),
    .num_nodes_i (num_nodes_i),
    .wr_en_o     (wr_en),
    .wr_addr_o   (wr_addr),
    .wr_data_o   (wr_data),
    .done_o      (wb_done)
  );

  feat_bram feat_bram_i (
    .clk       (clk),
    .wr_en_i   (wr_en),
    .wr_addr_i (wr_addr),
    .wr_data_i (wr_data),
    .rd_addr_i (rd_addr_i),
    .rd_data_o (rd_data_o)
  );

  debug_monitor debug_monitor_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .clear_i         (dbg_clear_i),
    .phase_start_i   (phase_start),
    .wr_en_i         (wr_en),
    .wr_addr_i       (wr_addr),
    .wr_data_i       (wr_data),
    .watch_addr_i    (watch_addr_i),
    .debug_flags_o   (debug_flags_o),
    .debug_count_o   (debug_count_o),
    .debug_capture_o (debug_capture_o)
  );

endmodule

`default_nettype wire

//--- dv/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD = 100
) (
  output logic clk_o
);

  initial clk_o = 1'b0;

  always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

`default_nettype wire

//--- dv/gat_debug_tb.sv
`default_nettype none

module gat_debug_tb;

  localparam string       TESTS_FILE = "dv/gat_debug_tests.txt";
  localparam logic [39:0] OP_RUN     = 40'("run");
  localparam logic [39:0] OP_CLEAR   = 40'("clear");
  localparam logic [39:0] OP_READ    = 40'("read");

  logic                clk;
  logic                rst_n;
  logic                start;
  gat_pkg::node_cnt_t  num_nodes;
  gat_pkg::feat_addr_t watch_addr;
  logic                dbg_clear;
  gat_pkg::feat_addr_t rd_addr;
  logic                busy;
  logic                done;
  gat_pkg::feat_word_t rd_data;
  logic [31:0]         debug_flags;
  logic [31:0]         debug_count;
  logic [31:0]         debug_capture;

  // one entry per test line
  logic [39:0] op_q[$];
  int          nodes_q[$];
  int          watch_q[$];
  int          rd_q[$];
  logic [31:0] exp_flags_q[$];
  logic [31:0] exp_count_q[$];
  logic [31:0] exp_capture_q[$];
  logic [31:0] exp_rd_q[$];

  int   budget_cycles;
  logic budget_ready;

  tb_clk_gen #(.PERIOD(100)) clk_gen_i (.clk_o(clk));

  gat_debug_top gat_debug_top_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .start_i         (start),
    .num_nodes_i     (num_nodes),
    .watch_addr_i    (watch_addr),
    .dbg_clear_i     (dbg_clear),
    .rd_addr_i       (rd_addr),
    .busy_o          (busy),
    .done_o          (done),
    .rd_data_o       (rd_data),
    .debug_flags_o   (debug_flags),
    .debug_count_o   (debug_count),
    .debug_capture_o (debug_capture)
  );

  // ------------------------------
  // checking helpers
  // ------------------------------

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH at time %0t: %s expected 0x%08h, got 0x%08h",
               $time, name, expected, actual);
      $display("*** TEST FAILED ***");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic abort_run(input string msg);
    $display("ERROR at time %0t: %s", $time, msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "run aborted");
  endtask

  task automatic check_debug_words(input int idx);
    check_value("debug_flags_o", exp_flags_q[idx], debug_flags);
    check_value("debug_count_o", exp_count_q[idx], debug_count);
    check_value("debug_capture_o", exp_capture_q[idx], debug_capture);
  endtask

  task automatic load_tests();
    int          fd;
    int          n_fields;
    int          nodes;
    int          watch;
    int          rd;
    logic [39:0] op;
    logic [31:0] flags;
    logic [31:0] count;
    logic [31:0] capture;
    logic [31:0] rdata;
    string       line;
    fd = $fopen(TESTS_FILE, "r");
    if (fd == 0) begin
      abort_run({"cannot open the tests file ", TESTS_FILE});
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line[0] != "#") begin
          n_fields = $sscanf(line, "%s %d %d %d %h %d %h %h", op, nodes, watch, rd,
                             flags, count, capture, rdata);
          if (n_fields != 8) begin
            abort_run({"badly formed line in the tests file: ", line});
          end else begin
            op_q.push_back(op);
            nodes_q.push_back(nodes);
            watch_q.push_back(watch);
            rd_q.push_back(rd);
            exp_flags_q.push_back(flags);
            exp_count_q.push_back(count);
            exp_capture_q.push_back(capture);
            exp_rd_q.push_back(rdata);
            // a layer run takes 5N+5 cycles plus the idle gap before it
            budget_cycles += (op == OP_RUN) ? 5 * nodes + 20 : 10;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // ------------------------------
  // operations
  // ------------------------------

  task automatic run_layer(input int idx);
    int gap;
    int extra_at;
    int cyc;
    bit finished;
    gap      = $urandom % 4;
    extra_at = 2 + $urandom % 3;
    repeat (gap) @(negedge clk);
    @(negedge clk);
    num_nodes  = gat_pkg::node_cnt_t'(nodes_q[idx]);
    watch_addr = gat_pkg::feat_addr_t'(watch_q[idx]);
    start      = 1'b1;
    cyc        = 0;
    finished   = 1'b0;
    while (!finished) begin
      @(negedge clk);
      cyc++;
      start = (cyc == extra_at);  // a second pulse while busy must be ignored
      if (done) begin
        finished = 1'b1;
        check_value("busy_o", 32'd0, 32'(busy));
      end else begin
        check_value("busy_o", 32'd1, 32'(busy));
      end
    end
    start = 1'b0;
    @(negedge clk);
    check_value("done_o", 32'd0, 32'(done));
    check_value("busy_o", 32'd0, 32'(busy));  // no extra run was queued
    check_debug_words(idx);
  endtask

  task automatic clear_debug(input int idx);
    @(negedge clk);
    watch_addr = gat_pkg::feat_addr_t'(watch_q[idx]);
    dbg_clear  = 1'b1;
    @(negedge clk);
    dbg_clear = 1'b0;
    check_debug_words(idx);
  endtask

  task automatic read_word(input int idx);
    @(negedge clk);
    watch_addr = gat_pkg::feat_addr_t'(watch_q[idx]);
    rd_addr    = gat_pkg::feat_addr_t'(rd_q[idx]);
    @(negedge clk);
    check_value("rd_data_o", exp_rd_q[idx], rd_data);
    check_debug_words(idx);
  endtask

  initial begin : watchdog
    wait (budget_ready);
    repeat (budget_cycles) @(posedge clk);
    $display("ERROR: timeout, the tests did not finish within %0d cycles", budget_cycles);
    $display("*** TEST FAILED ***");
    $fatal(1, "watchdog expired");
  end

  initial begin : main
    int idx;
    rst_n         = 1'b0;
    start         = 1'b0;
    num_nodes     = '0;
    watch_addr    = '0;
    dbg_clear     = 1'b0;
    rd_addr       = '0;
    budget_cycles = 100;
    budget_ready  = 1'b0;
    void'($urandom(32));
    load_tests();
    budget_ready = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_value("busy_o", 32'd0, 32'(busy));
    check_value("done_o", 32'd0, 32'(done));
    check_value("debug_flags_o", 32'd0, debug_flags);
    check_value("debug_count_o", 32'd0, debug_count);
    check_value("debug_capture_o", 32'd0, debug_capture);
    for (idx = 0; idx < op_q.size(); idx++) begin
      if (op_q[idx] == OP_RUN) begin
        run_layer(idx);
      end else if (op_q[idx] == OP_CLEAR) begin
        clear_debug(idx);
      end else if (op_q[idx] == OP_READ) begin
        read_word(idx);
      end else begin
        abort_run("unknown operation in the tests file");
      end
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/gat_debug_tests.txt
# op num_nodes watch_addr rd_addr flags(hex) count capture(hex) rd_data(hex)
# addresses and counts are decimal, rd_data is checked on read lines only
run     4   19    0 0000001f 1 00000003 00000000
read    4   19   19 0000001f 1 00000003 00000003
run     4   21    0 0000001f 2 00010001 00000000
read    4   21   22 0000001f 2 00010001 00010002
read    4   21   19 0000001f 2 00010001 00000003
clear   4   21    0 00000000 0 00000000 00000000
run   200  500    0 0000001f 1 00020054 00000000
run   200  800    0 0000003f 2 000300b8 00000000
read  200  800  800 0000003f 2 000300b8 000300b8
read  200  800  500 0000003f 2 000300b8 00020054
run     4   33    0 0000003f 3 00040001 00000000
read    4   33   33 0000003f 3 00040001 00040001
read    4   33   19 0000003f 3 00040001 00000003
clear   4   33    0 00000000 0 00000000 00000000
run   255  300    0 0000001f 1 00050021 00000000
read  255  300  267 0000001f 1 00050021 00050000
read  255  300  521 0000001f 1 00050021 000500fe
run     1   22    0 0000001f 2 00060000 00000000
read    1   22   22 0000001f 2 00060000 00060000
read    1   22   21 0000001f 2 00060000 00010001
run   143    2    0 0000003f 3 00070009 00000000
read  143    2    0 0000003f 3 00070009 00070007
read  143    2   16 0000003f 3 00070009 00070017
clear 143    2    0 00000000 0 00000000 00000000
read  143    2    2 00000000 0 00000000 00070009

//--- filelist.f
+incdir+common
common/gat_pkg.sv
hw/stage_engine.sv
hw/gat_layer_ctrl.sv
hw/feat_writeback.sv
hw/feat_bram.sv
debug/debug_monitor.sv
hw/gat_debug_top.sv
dv/tb_clk_gen.sv
dv/gat_debug_tb.sv

//--- Makefile
# Verilator build and run of the GAT debug testbench

VERILATOR ?= verilator
TOP       ?= gat_debug_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SRCS    := $(shell grep -v '^+' filelist.f)
HDRS    := common/gat_cfg.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): filelist.f $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f filelist.f

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
